/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

  // rv32 integer widths
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int opcode_w = 7;

  // one register or one instruction word
  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes handled by this core
  // op_other is the catch-all, decodes as a no-op
  typedef enum logic [opcode_w-1:0] {
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_system  = 7'b1110011,
    op_other   = 7'b0000000
  } opcode_e;

  // alu funct3, shared by reg-imm and reg-reg groups
  typedef enum logic [2:0] {
    f3_add_sub = 3'b000,
    f3_sll     = 3'b001,
    f3_slt     = 3'b010,
    f3_sltu    = 3'b011,
    f3_xor     = 3'b100,
    f3_srl_sra = 3'b101,
    f3_or      = 3'b110,
    f3_and     = 3'b111
  } funct3_e;

  // funct7 picking sub and sra, the base encodings use zero
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // field lsb positions in the instruction word
  localparam int rd_lsb = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb = 15;
  localparam int rs2_lsb = 20;
  localparam int funct7_lsb = 25;
  // I immediate is insn[31:20], U immediate is insn[31:12]
  localparam int imm_i_lsb = 20;
  localparam int imm_u_lsb = 12;
  // shifts only look at the low bits of operand b
  localparam int shamt_w = 5;

endpackage

/* logic/pipe_pkg.sv */
package pipe_pkg;
  import rv_isa_pkg::*;

  // alu functions, pass_b feeds lui straight through
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // writeback status, no stall reasons in this core
  typedef enum logic [1:0] {
    st_reset,
    st_valid,
    st_halted
  } cycle_status_e;

  // fetch to decode
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t insn;
  } fetched_t;

  // decode to execute
  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     insn;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    alu_op_e   alu_op;
    // operand b from imm, operand a from pc
    logic      use_imm;
    logic      use_pc;
    logic      we;
    logic      ecall;
  } decoded_t;

  // execute to writeback, also the forwarding source
  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     insn;
    reg_addr_t rd;
    word_t     data;
    logic      we;
    logic      ecall;
  } result_t;

  // retired instruction as seen at the top
  typedef struct packed {
    word_t     pc;
    word_t     insn;
    reg_addr_t rd;
    word_t     data;
    logic      we;
  } trace_t;

endpackage

/* logic/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage
  import rv_isa_pkg::*, pipe_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic     clk,
  input  logic     rst,
  output word_t    pc_to_imem,
  input  word_t    insn,
  output fetched_t fetched
);

  word_t pc;

  // imem answers combinationally for the current pc
  assign pc_to_imem = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
      fetched.valid <= 1'b0;
    end else begin
      // straight-line fetch with no redirects
      pc <= pc + word_t'(4);
      fetched <= '{valid: 1'b1, pc: pc, insn: insn};
    end
  end

  // pc stays word aligned
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage
  import rv_isa_pkg::*, pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  fetched_t  fetched,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output decoded_t  decoded
);

  word_t      insn;
  opcode_e    opcode;
  funct3_e    funct3;
  logic [6:0] funct7;
  logic       alt;
  word_t      imm_i;
  word_t      imm_u;
  alu_op_e    f3_op;
  decoded_t   dec_d;

  // field extraction
  assign insn = fetched.insn;
  assign opcode = opcode_e'(insn[opcode_w-1:0]);
  assign funct3 = funct3_e'(insn[funct3_lsb +: 3]);
  assign funct7 = insn[funct7_lsb +: 7];
  assign alt = (funct7 == funct7_alt);

  // sign-extended I, upper U
  assign imm_i = {{imm_i_lsb{insn[xlen-1]}}, insn[xlen-1:imm_i_lsb]};
  assign imm_u = {insn[xlen-1:imm_u_lsb], {imm_u_lsb{1'b0}}};

  // register read request, data comes back this cycle
  assign rs1_addr = insn[rs1_lsb +: reg_addr_w];
  assign rs2_addr = insn[rs2_lsb +: reg_addr_w];

  // funct3 to alu function, alt bit only matters for reg-reg add and shifts
  always_comb begin
    f3_op = alu_add;
    case (funct3)
      f3_add_sub: f3_op = alt ? alu_sub : alu_add;
      f3_sll:     f3_op = alu_sll;
      f3_slt:     f3_op = alu_slt;
      f3_sltu:    f3_op = alu_sltu;
      f3_xor:     f3_op = alu_xor;
      f3_srl_sra: f3_op = alt ? alu_sra : alu_srl;
      f3_or:      f3_op = alu_or;
      f3_and:     f3_op = alu_and;
    endcase
  end

  always_comb begin
    dec_d = '0;
    dec_d.valid = fetched.valid;
    dec_d.pc = fetched.pc;
    dec_d.insn = insn;
    dec_d.rd = insn[rd_lsb +: reg_addr_w];
    dec_d.rs1 = rs1_addr;
    dec_d.rs2 = rs2_addr;
    dec_d.rs1_data = rs1_data;
    dec_d.rs2_data = rs2_data;
    dec_d.alu_op = alu_add;
    case (opcode)
      op_lui: begin
        dec_d.imm = imm_u;
        dec_d.alu_op = alu_pass_b;
        dec_d.use_imm = 1'b1;
        dec_d.we = 1'b1;
      end
      op_auipc: begin
        dec_d.imm = imm_u;
        dec_d.use_imm = 1'b1;
        dec_d.use_pc = 1'b1;
        dec_d.we = 1'b1;
      end
      op_reg_imm: begin
        dec_d.imm = imm_i;
        dec_d.use_imm = 1'b1;
        // addi has no subtract form, funct7 is imm bits there
        dec_d.alu_op = (funct3 == f3_add_sub) ? alu_add : f3_op;
        // shift immediates need a clean funct7
        case (funct3)
          f3_sll:     dec_d.we = (funct7 == '0);
          f3_srl_sra: dec_d.we = (funct7 == '0) || alt;
          default:    dec_d.we = 1'b1;
        endcase
      end
      op_reg_reg: begin
        dec_d.alu_op = f3_op;
        dec_d.we = (funct7 == '0) || (alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
      end
      op_system: begin
        // only the all-zero form is ecall
        dec_d.ecall = (insn[xlen-1:rd_lsb] == '0);
      end
      default: begin
        // unknown encoding, retires with no write
        dec_d.we = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      decoded.valid <= 1'b0;
    end else begin
      decoded <= dec_d;
    end
  end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/100ps

module reg_file
  import rv_isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data,
  input  logic      wr_en
);

  word_t regs [32];

  // x0 reads zero, a same-cycle write shows through to the read
  assign rs1_data = (rs1_addr == '0) ? '0 :
                    (wr_en && (wr_addr == rs1_addr)) ? wr_data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    (wr_en && (wr_addr == rs2_addr)) ? wr_data : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      // writes to x0 are dropped
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 storage never leaves zero
  assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage
  import rv_isa_pkg::*, pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  decoded_t decoded,
  input  result_t  wb_fwd,
  output result_t  result
);

  logic               fwd_ok;
  word_t              rs1_val;
  word_t              rs2_val;
  word_t              op_a;
  word_t              op_b;
  logic [shamt_w-1:0] shamt;
  word_t              alu_y;

  // bypass from the packet now in writeback, back-to-back case
  // older results already came through the register file
  assign fwd_ok = wb_fwd.valid && wb_fwd.we && (wb_fwd.rd != '0);
  assign rs1_val = (fwd_ok && (wb_fwd.rd == decoded.rs1)) ? wb_fwd.data : decoded.rs1_data;
  assign rs2_val = (fwd_ok && (wb_fwd.rd == decoded.rs2)) ? wb_fwd.data : decoded.rs2_data;

  // operand select
  assign op_a = decoded.use_pc ? decoded.pc : rs1_val;
  assign op_b = decoded.use_imm ? decoded.imm : rs2_val;
  assign shamt = op_b[shamt_w-1:0];

  always_comb begin
    case (decoded.alu_op)
      alu_add:    alu_y = op_a + op_b;
      alu_sub:    alu_y = op_a - op_b;
      alu_sll:    alu_y = op_a << shamt;
      alu_slt:    alu_y = word_t'($signed(op_a) < $signed(op_b));
      alu_sltu:   alu_y = word_t'(op_a < op_b);
      alu_xor:    alu_y = op_a ^ op_b;
      alu_srl:    alu_y = op_a >> shamt;
      alu_sra:    alu_y = word_t'($signed(op_a) >>> shamt);
      alu_or:     alu_y = op_a | op_b;
      alu_and:    alu_y = op_a & op_b;
      alu_pass_b: alu_y = op_b;
      default:    alu_y = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
    end else begin
      result <= '{
        valid: decoded.valid,
        pc:    decoded.pc,
        insn:  decoded.insn,
        rd:    decoded.rd,
        data:  alu_y,
        we:    decoded.we,
        ecall: decoded.ecall
      };
    end
  end

endmodule

/* logic/writeback_stage.sv */
`timescale 1ns/100ps

module writeback_stage
  import rv_isa_pkg::*, pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  result_t   result,
  output reg_addr_t wr_addr,
  output word_t     wr_data,
  output logic      wr_en,
  output trace_t    trace,
  output logic      trace_valid,
  output logic      halt
);

  cycle_status_e status;
  logic          ecall_q;
  logic          blocked;
  logic          retire;

  assign halt = (status == st_halted);
  // nothing retires behind an ecall
  assign blocked = ecall_q || halt;
  assign retire = result.valid && !blocked;

  // register write lands on the edge that loads the trace
  assign wr_addr = result.rd;
  assign wr_data = result.data;
  assign wr_en = retire && result.we;

  always_ff @(posedge clk) begin
    if (rst) begin
      status <= st_reset;
      ecall_q <= 1'b0;
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= retire;
      ecall_q <= retire && result.ecall;
      // halt follows the ecall strobe and sticks until reset
      if (ecall_q) begin
        status <= st_halted;
      end else if (status == st_reset) begin
        status <= st_valid;
      end
    end
    trace <= '{pc: result.pc, insn: result.insn, rd: result.rd, data: result.data, we: result.we};
  end

  // no strobe once halted
  assert property (@(posedge clk) disable iff (rst) halt |-> !trace_valid);

endmodule

/* logic/rv_pipe_top.sv */
`timescale 1ns/100ps

module rv_pipe_top
  import rv_isa_pkg::*, pipe_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic   clk,
  input  logic   rst,
  output word_t  pc_to_imem,
  input  word_t  insn,
  output trace_t trace,
  output logic   trace_valid,
  output logic   halt
);

  fetched_t  fetched;
  decoded_t  decoded;
  result_t   result;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t wr_addr;
  word_t     wr_data;
  logic      wr_en;

  // input side
  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) fetch0 (
    .clk        (clk),
    .rst        (rst),
    .pc_to_imem (pc_to_imem),
    .insn       (insn),
    .fetched    (fetched)
  );

  decode_stage decode0 (
    .clk      (clk),
    .rst      (rst),
    .fetched  (fetched),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .decoded  (decoded)
  );

  reg_file rf0 (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_en    (wr_en)
  );

  // forwarding source is the packet handed to writeback
  execute_stage execute0 (
    .clk     (clk),
    .rst     (rst),
    .decoded (decoded),
    .wb_fwd  (result),
    .result  (result)
  );

  // output side
  writeback_stage writeback0 (
    .clk         (clk),
    .rst         (rst),
    .result      (result),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_en       (wr_en),
    .trace       (trace),
    .trace_valid (trace_valid),
    .halt        (halt)
  );

endmodule

/* sim/tb_rv_pipe.sv */
`timescale 1ns/100ps

module tb_rv_pipe
  import rv_isa_pkg::*, pipe_pkg::*;
;

  localparam word_t RESET_PC = 32'h0000_0100;
  localparam int reset_cycles = 8;
  localparam int n_tests = 4;
  // program lengths per test including the ecall
  localparam int len_mixed = 48;
  localparam int len_chain = 24;
  localparam int len_zero = 16;
  localparam int len_unknown = 16;
  localparam int cycle_limit = len_mixed + len_chain + len_zero + len_unknown
                               + n_tests * (reset_cycles + 20);
  localparam word_t ecall_insn = 32'h0000_0073;

  logic   clk;
  logic   rst;
  word_t  pc_to_imem;
  word_t  imem_insn;
  trace_t trace_out;
  logic   trace_valid;
  logic   halt;

  word_t  prog [64];
  int     prog_len;
  word_t  ref_regs [32];
  int     ref_idx;
  int     fetch_cnt;
  logic   halt_exp;
  trace_t exp_trace;
  logic [31:0] lfsr_state;
  int     errors;
  int     checks;
  int     cycles;
  int     test_start_errors;

  rv_pipe_top #(
    .RESET_PC(RESET_PC)
  ) dut0 (
    .clk         (clk),
    .rst         (rst),
    .pc_to_imem  (pc_to_imem),
    .insn        (imem_insn),
    .trace       (trace_out),
    .trace_valid (trace_valid),
    .halt        (halt)
  );

  always #50 clk = ~clk;

  // galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit with the msb first
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic int test_length(int mode);
    case (mode)
      0: return len_mixed;
      1: return len_chain;
      2: return len_zero;
      default: return len_unknown;
    endcase
  endfunction

  function automatic string test_name(int mode);
    case (mode)
      0: return "mixed alu";
      1: return "dependent chain";
      2: return "x0 writes";
      default: return "unknown encodings";
    endcase
  endfunction

  // mode 0 mixed, 1 chain on previous rd, 2 heavy x0 use, 3 mostly unknown
  task automatic build_program(input int mode);
    int          kind;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   prev_rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    logic [19:0] imm20;
    word_t       w;
    prog_len = test_length(mode);
    prev_rd = '0;
    for (int i = 0; i < prog_len - 1; i++) begin
      kind = int'(take_bits(3));
      // only x0..x7 so operands get reused
      rd = reg_addr_t'(take_bits(3));
      rs1 = reg_addr_t'(take_bits(3));
      rs2 = reg_addr_t'(take_bits(3));
      f3 = 3'(take_bits(3));
      case (mode)
        1: begin
          if (rd == '0) rd = 5'd1;
          rs1 = prev_rd;
          if (kind[0]) rs2 = prev_rd;
          kind = kind[1] ? 4 : 2;
        end
        2: begin
          if (kind[1]) rd = '0;
          if (kind[2]) rs1 = '0;
          if (kind == 7) kind = 5;
        end
        3: if (kind[0]) kind = 7;
        default: ;
      endcase
      case (kind)
        0, 1: begin
          imm20 = 20'(take_bits(20));
          w = {imm20, rd, (kind == 0) ? 7'h37 : 7'h17};
        end
        2, 3: begin
          imm12 = 12'(take_bits(12));
          // shift immediates carry funct7 in the top bits
          if (f3 == 3'd1) imm12[11:5] = 7'h00;
          if (f3 == 3'd5) imm12[11:5] = take_bits(1) ? 7'h20 : 7'h00;
          w = {imm12, rs1, f3, rd, 7'h13};
        end
        7: begin
          // custom-0 opcode or an m-extension reg-reg form
          if (take_bits(1)) w = {25'(take_bits(25)), 7'h0b};
          else w = {7'h01, rs2, rs1, f3, rd, 7'h33};
        end
        default: begin
          f7 = (take_bits(1) && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
          w = {f7, rs2, rs1, f3, rd, 7'h33};
        end
      endcase
      prog[i] = w;
      prev_rd = rd;
    end
    prog[prog_len - 1] = ecall_insn;
  endtask

  // zero beyond the program
  function automatic word_t imem_word(word_t addr);
    int idx;
    idx = int'((addr - RESET_PC) >> 2);
    if (addr[1:0] == 2'b00 && idx >= 0 && idx < prog_len) return prog[idx];
    return '0;
  endfunction

  // rv32i alu semantics by funct3 where alt selects sub and sra
  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t x, word_t y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3: return (x < y) ? 32'd1 : 32'd0;
      3'd4: return x ^ y;
      3'd5: return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  // expected retirement from architectural state with zero data when nothing is written
  function automatic trace_t reference_trace(word_t pc, word_t ins);
    trace_t     t;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_u;
    f3 = ins[14:12];
    f7 = ins[31:25];
    a = ref_regs[ins[19:15]];
    b = ref_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'h000};
    t.pc = pc;
    t.insn = ins;
    t.rd = ins[11:7];
    t.data = '0;
    t.we = 1'b0;
    case (ins[6:0])
      7'h37: begin
        t.we = 1'b1;
        t.data = imm_u;
      end
      7'h17: begin
        t.we = 1'b1;
        t.data = pc + imm_u;
      end
      7'h13: begin
        if (f3 == 3'd1) t.we = (f7 == 7'h00);
        else if (f3 == 3'd5) t.we = (f7 == 7'h00) || (f7 == 7'h20);
        else t.we = 1'b1;
        t.data = alu_ref(f3, (f3 == 3'd5) && (f7 == 7'h20), a, imm_i);
      end
      7'h33: begin
        t.we = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
        t.data = alu_ref(f3, f7 == 7'h20, a, b);
      end
      default: ;
    endcase
    if (!t.we) t.data = '0;
    return t;
  endfunction

  // data only matters when the write is enabled
  task automatic compare_trace(input trace_t got, input trace_t exp);
    checks++;
    if (got.pc !== exp.pc || got.insn !== exp.insn || got.rd !== exp.rd
        || got.we !== exp.we || (exp.we && got.data !== exp.data)) begin
      $display("error at %0t: trace pc %h insn %h rd %0d data %h we %b", $time,
               got.pc, got.insn, got.rd, got.data, got.we);
      $display("  expected pc %h insn %h rd %0d data %h we %b",
               exp.pc, exp.insn, exp.rd, exp.data, exp.we);
      errors++;
    end
  endtask

  task automatic compare_halt(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t: halt %b, expected %b", $time, got, exp);
      errors++;
    end
  endtask

  task automatic compare_pc(input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t: pc_to_imem %h, expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic compare_strobe(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t: trace_valid %b, expected %b", $time, got, exp);
      errors++;
    end
  endtask

  // instruction server answers the pc shortly after each edge
  always @(posedge clk) begin
    #1;
    imem_insn = imem_word(pc_to_imem);
  end

  // outputs settle after the edge and are sampled on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      ref_idx = 0;
      fetch_cnt = 0;
      halt_exp = 1'b0;
      for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    end else begin
      compare_halt(halt, halt_exp);
      // one fetch per edge since reset released
      compare_pc(pc_to_imem, RESET_PC + word_t'(4 * fetch_cnt));
      // strobe three edges after the fetch edge
      compare_strobe(trace_valid, (fetch_cnt >= 4) && (fetch_cnt - 4 < prog_len));
      if (trace_valid) begin
        if (halt_exp) begin
          $display("unexpected strobe at pc %h after the ecall retired", trace_out.pc);
          errors++;
        end else if (ref_idx >= prog_len) begin
          $display("strobe at pc %h beyond the end of the program", trace_out.pc);
          errors++;
        end else begin
          exp_trace = reference_trace(RESET_PC + word_t'(4 * ref_idx), prog[ref_idx]);
          compare_trace(trace_out, exp_trace);
          if (exp_trace.we && exp_trace.rd != '0) ref_regs[exp_trace.rd] = exp_trace.data;
          // halt expected from the next cycle on
          if (prog[ref_idx] == ecall_insn) halt_exp = 1'b1;
          ref_idx++;
        end
      end
      fetch_cnt++;
    end
  end

  // run limit sized from program lengths
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the DUT did not finish the tests", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    imem_insn = '0;
    lfsr_state = 32'hce1c_2136;
    prog_len = 0;
    errors = 0;
    checks = 0;
    cycles = 0;
    for (int t = 0; t < n_tests; t++) begin
      test_start_errors = errors;
      @(posedge clk);
      #1;
      rst = 1'b1;
      build_program(t);
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst = 1'b0;
      while (!halt) @(negedge clk);
      // quiet window after halt
      repeat (6) @(posedge clk);
      if (ref_idx != prog_len) begin
        $display("test %0d retired %0d of %0d instructions", t, ref_idx, prog_len);
        errors++;
      end
      $display("test %0d %s: %0d instructions, %0d errors", t, test_name(t),
               prog_len, errors - test_start_errors);
    end
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* build.f */
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/rv_pipe_top.sv
sim/tb_rv_pipe.sv

/* Makefile */
# Verilator build and run for the RV32 pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_pipe
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
